// File: source/board_io_pkg.sv
// Widths, configuration words and pad structs; command words are kept in unreversed bit order
`default_nettype none

package board_io_pkg;

    // Synchronizer depths
    localparam int SYNC_STAGES      = 2;
    localparam int BOOT_SYNC_STAGES = 3;

    // Bus widths
    localparam int FLASH_DQ_W   = 16;
    localparam int FLASH_ADDR_W = 23;
    localparam int ICAP_WORD_W  = 32;
    localparam int STATUS_W     = 9;

    // Configuration port command words
    localparam logic [ICAP_WORD_W-1:0] ICAP_DUMMY_WORD     = 32'hFFFF_FFFF;
    localparam logic [ICAP_WORD_W-1:0] ICAP_SYNC_WORD      = 32'hAA99_5566;
    localparam logic [ICAP_WORD_W-1:0] ICAP_NOOP_WORD      = 32'h2000_0000;
    // Type 1 write of one word to the CMD register
    localparam logic [ICAP_WORD_W-1:0] ICAP_WRITE_CMD_WORD = 32'h3000_8001;
    localparam logic [ICAP_WORD_W-1:0] ICAP_IPROG_WORD     = 32'h0000_000F;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SYNC,
        ST_NOOP_A,
        ST_CMD,
        ST_IPROG,
        ST_NOOP_B
    } icap_state_e;

    typedef struct packed {
        logic sfp_1_npres;
        logic sfp_2_npres;
        logic sfp_1_los;
        logic sfp_2_los;
        logic sfp_i2c_scl;
        logic sfp_1_i2c_sda;
        logic sfp_2_i2c_sda;
        logic eeprom_i2c_scl;
        logic eeprom_i2c_sda;
    } board_status_t;

    // _t is the release bit, pad floats while it is set
    typedef struct packed {
        logic sfp_scl_o;
        logic sfp_scl_t;
        logic sfp_1_sda_o;
        logic sfp_1_sda_t;
        logic sfp_2_sda_o;
        logic sfp_2_sda_t;
        logic eeprom_scl_o;
        logic eeprom_scl_t;
        logic eeprom_sda_o;
        logic eeprom_sda_t;
    } i2c_drive_t;

    typedef struct packed {
        logic [FLASH_DQ_W-1:0]   dq_o;
        logic                    dq_oe;
        logic [FLASH_ADDR_W-1:0] addr;
        logic                    region;
        logic                    region_oe;
        logic                    ce_n;
        logic                    oe_n;
        logic                    we_n;
        logic                    adv_n;
    } flash_drive_t;

    // All lines released
    localparam i2c_drive_t I2C_DRIVE_IDLE = '{default: 1'b1};

    // Deselected, strobes inactive, no pin driven
    localparam flash_drive_t FLASH_DRIVE_IDLE = '{
        dq_o:      '0,
        dq_oe:     1'b0,
        addr:      '0,
        region:    1'b0,
        region_oe: 1'b0,
        ce_n:      1'b1,
        oe_n:      1'b1,
        we_n:      1'b1,
        adv_n:     1'b1
    };

endpackage

`default_nettype wire

// File: source/signal_sync.sv
// Plain flop chain for slow or quasi-static inputs; a multi-bit bus is not captured coherently
`timescale 1ns/100ps
`default_nettype none

module signal_sync import board_io_pkg::*; #(
    parameter int WIDTH = 1
) (
    input  wire              pcie_user_clk,
    input  wire              rst_i,
    input  wire  [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o
);

    logic [SYNC_STAGES-1:0][WIDTH-1:0] sync_q;

    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= data_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign data_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: source/i2c_pad_reg.sv
// Open-drain style pads; the board must provide pull-ups so a released line reads 1
`timescale 1ns/100ps
`default_nettype none

module i2c_pad_reg import board_io_pkg::*; (
    input  wire        pcie_user_clk,
    input  wire        rst_i,
    input  i2c_drive_t drive_i,
    inout  wire        sfp_i2c_scl_io,
    inout  wire        sfp_1_i2c_sda_io,
    inout  wire        sfp_2_i2c_sda_io,
    inout  wire        eeprom_i2c_scl_io,
    inout  wire        eeprom_i2c_sda_io
);

    i2c_drive_t drive_q;

    // One register stage between core logic and the pads
    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            drive_q <= I2C_DRIVE_IDLE;
        end else begin
            drive_q <= drive_i;
        end
    end

    // SFP cage bus
    assign sfp_i2c_scl_io   = drive_q.sfp_scl_t   ? 1'bz : drive_q.sfp_scl_o;
    assign sfp_1_i2c_sda_io = drive_q.sfp_1_sda_t ? 1'bz : drive_q.sfp_1_sda_o;
    assign sfp_2_i2c_sda_io = drive_q.sfp_2_sda_t ? 1'bz : drive_q.sfp_2_sda_o;

    // Board EEPROM bus
    assign eeprom_i2c_scl_io = drive_q.eeprom_scl_t ? 1'bz : drive_q.eeprom_scl_o;
    assign eeprom_i2c_sda_io = drive_q.eeprom_sda_t ? 1'bz : drive_q.eeprom_sda_o;

endmodule

`default_nettype wire

// File: source/flash_pad_reg.sv
// Parallel flash pins registered once; dq and region float unless their registered enable is set
`timescale 1ns/100ps
`default_nettype none

module flash_pad_reg import board_io_pkg::*; (
    input  wire                     pcie_user_clk,
    input  wire                     rst_i,
    input  flash_drive_t            drive_i,
    inout  wire  [FLASH_DQ_W-1:0]   flash_dq_io,
    inout  wire                     flash_region_io,
    output logic [FLASH_ADDR_W-1:0] flash_addr_o,
    output logic                    flash_ce_n_o,
    output logic                    flash_oe_n_o,
    output logic                    flash_we_n_o,
    output logic                    flash_adv_n_o
);

    flash_drive_t drive_q;

    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            drive_q <= FLASH_DRIVE_IDLE;
        end else begin
            drive_q <= drive_i;
        end
    end

    // Bidirectional pins
    assign flash_dq_io     = drive_q.dq_oe ? drive_q.dq_o : {FLASH_DQ_W{1'bz}};
    assign flash_region_io = drive_q.region_oe ? drive_q.region : 1'bz;

    // Always driven
    assign flash_addr_o  = drive_q.addr;
    assign flash_ce_n_o  = drive_q.ce_n;
    assign flash_oe_n_o  = drive_q.oe_n;
    assign flash_we_n_o  = drive_q.we_n;
    assign flash_adv_n_o = drive_q.adv_n;

endmodule

`default_nettype wire

// File: source/icap_reboot_seq.sv
// Boot request is a level; icap_avail_i only gates the start, a running sequence is never stalled
`timescale 1ns/100ps
`default_nettype none

module icap_reboot_seq import board_io_pkg::*; (
    input  wire                    pcie_user_clk,
    input  wire                    rst_i,
    input  wire                    fpga_boot_i,
    input  wire                    icap_avail_i,
    output logic                   icap_csib_o,
    output logic                   icap_rdwrb_o,
    output logic [ICAP_WORD_W-1:0] icap_di_o
);

    logic [BOOT_SYNC_STAGES-1:0] boot_sync_q;
    icap_state_e                 state_q;
    logic                        csib_q;
    logic [ICAP_WORD_W-1:0]      di_q;
    logic                        start;

    // Configuration port wants each byte with its bit order swapped
    function automatic logic [ICAP_WORD_W-1:0] swap_byte_bits(
        input logic [ICAP_WORD_W-1:0] word
    );
        logic [ICAP_WORD_W-1:0] rev;
        for (int b = 0; b < ICAP_WORD_W / 8; b++) begin
            for (int i = 0; i < 8; i++) begin
                rev[8*b + i] = word[8*b + 7 - i];
            end
        end
        return rev;
    endfunction

    // Request crosses in from an asynchronous source
    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            boot_sync_q <= '0;
        end else begin
            boot_sync_q <= {boot_sync_q[BOOT_SYNC_STAGES-2:0], fpga_boot_i};
        end
    end

    // csib_q high means the idle word is already on the port
    assign start = boot_sync_q[BOOT_SYNC_STAGES-1] && icap_avail_i && csib_q;

    always_ff @(posedge pcie_user_clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            csib_q  <= 1'b1;
            di_q    <= ICAP_DUMMY_WORD;
        end else begin
            csib_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    csib_q <= !start;
                    di_q   <= ICAP_DUMMY_WORD;
                    if (start) begin
                        state_q <= ST_SYNC;
                    end
                end
                ST_SYNC: begin
                    di_q    <= ICAP_SYNC_WORD;
                    state_q <= ST_NOOP_A;
                end
                ST_NOOP_A: begin
                    di_q    <= ICAP_NOOP_WORD;
                    state_q <= ST_CMD;
                end
                ST_CMD: begin
                    di_q    <= ICAP_WRITE_CMD_WORD;
                    state_q <= ST_IPROG;
                end
                ST_IPROG: begin
                    di_q    <= ICAP_IPROG_WORD;
                    state_q <= ST_NOOP_B;
                end
                ST_NOOP_B: begin
                    // Last low cycle, idle state raises chip select
                    di_q    <= ICAP_NOOP_WORD;
                    state_q <= ST_IDLE;
                end
                default: begin
                    csib_q  <= 1'b1;
                    di_q    <= ICAP_DUMMY_WORD;
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign icap_csib_o  = csib_q;
    // Write-only use of the port
    assign icap_rdwrb_o = 1'b0;
    assign icap_di_o    = swap_byte_bits(di_q);

endmodule

`default_nettype wire

// File: source/board_io_top.sv
// I2C sense fields of status_pins_i are ignored, those bits are sampled from the pad nets
`timescale 1ns/100ps
`default_nettype none

module board_io_top import board_io_pkg::*; (
    input  wire                     pcie_user_clk,
    input  wire                     rst_i,
    input  wire                     fpga_boot_i,
    input  wire                     icap_avail_i,
    input  board_status_t           status_pins_i,
    input  i2c_drive_t              i2c_drive_i,
    input  flash_drive_t            flash_drive_i,
    output board_status_t           status_o,
    output logic [FLASH_DQ_W-1:0]   flash_dq_sync_o,
    inout  wire                     sfp_i2c_scl_io,
    inout  wire                     sfp_1_i2c_sda_io,
    inout  wire                     sfp_2_i2c_sda_io,
    inout  wire                     eeprom_i2c_scl_io,
    inout  wire                     eeprom_i2c_sda_io,
    inout  wire  [FLASH_DQ_W-1:0]   flash_dq_io,
    inout  wire                     flash_region_io,
    output logic [FLASH_ADDR_W-1:0] flash_addr_o,
    output logic                    flash_ce_n_o,
    output logic                    flash_oe_n_o,
    output logic                    flash_we_n_o,
    output logic                    flash_adv_n_o,
    output logic                    icap_csib_o,
    output logic                    icap_rdwrb_o,
    output logic [ICAP_WORD_W-1:0]  icap_di_o
);

    board_status_t status_raw;

    // SFP pins plus the live I2C line levels
    assign status_raw = '{
        sfp_1_npres:    status_pins_i.sfp_1_npres,
        sfp_2_npres:    status_pins_i.sfp_2_npres,
        sfp_1_los:      status_pins_i.sfp_1_los,
        sfp_2_los:      status_pins_i.sfp_2_los,
        sfp_i2c_scl:    sfp_i2c_scl_io,
        sfp_1_i2c_sda:  sfp_1_i2c_sda_io,
        sfp_2_i2c_sda:  sfp_2_i2c_sda_io,
        eeprom_i2c_scl: eeprom_i2c_scl_io,
        eeprom_i2c_sda: eeprom_i2c_sda_io
    };

    icap_reboot_seq u_icap_reboot_seq (
        .pcie_user_clk (pcie_user_clk),
        .rst_i         (rst_i),
        .fpga_boot_i   (fpga_boot_i),
        .icap_avail_i  (icap_avail_i),
        .icap_csib_o   (icap_csib_o),
        .icap_rdwrb_o  (icap_rdwrb_o),
        .icap_di_o     (icap_di_o)
    );

    signal_sync #(
        .WIDTH (STATUS_W)
    ) u_status_sync (
        .pcie_user_clk (pcie_user_clk),
        .rst_i         (rst_i),
        .data_i        (status_raw),
        .data_o        (status_o)
    );

    // Reads back whatever is on the bus, including our own drive
    signal_sync #(
        .WIDTH (FLASH_DQ_W)
    ) u_dq_sync (
        .pcie_user_clk (pcie_user_clk),
        .rst_i         (rst_i),
        .data_i        (flash_dq_io),
        .data_o        (flash_dq_sync_o)
    );

    i2c_pad_reg u_i2c_pad_reg (
        .pcie_user_clk     (pcie_user_clk),
        .rst_i             (rst_i),
        .drive_i           (i2c_drive_i),
        .sfp_i2c_scl_io    (sfp_i2c_scl_io),
        .sfp_1_i2c_sda_io  (sfp_1_i2c_sda_io),
        .sfp_2_i2c_sda_io  (sfp_2_i2c_sda_io),
        .eeprom_i2c_scl_io (eeprom_i2c_scl_io),
        .eeprom_i2c_sda_io (eeprom_i2c_sda_io)
    );

    flash_pad_reg u_flash_pad_reg (
        .pcie_user_clk   (pcie_user_clk),
        .rst_i           (rst_i),
        .drive_i         (flash_drive_i),
        .flash_dq_io     (flash_dq_io),
        .flash_region_io (flash_region_io),
        .flash_addr_o    (flash_addr_o),
        .flash_ce_n_o    (flash_ce_n_o),
        .flash_oe_n_o    (flash_oe_n_o),
        .flash_we_n_o    (flash_we_n_o),
        .flash_adv_n_o   (flash_adv_n_o)
    );

endmodule

`default_nettype wire

// File: tb/board_io_properties.sv
// Bound into board_io_top; assumes the testbench never drives flash_dq_io while the enable is set
`timescale 1ns/100ps
`default_nettype none

module board_io_properties import board_io_pkg::*; (
    input wire                  pcie_user_clk,
    input wire                  rst_i,
    input wire                  icap_csib_i,
    input wire                  icap_rdwrb_i,
    input wire                  dq_oe_i,
    input wire [FLASH_DQ_W-1:0] flash_dq_i
);

    // One command sequence is six low cycles
    csib_six_low: assert property (@(posedge pcie_user_clk) disable iff (rst_i)
        $fell(icap_csib_i) |-> (!icap_csib_i) [*6] ##1 icap_csib_i)
        else $error("chip select low for other than six cycles");

    rdwrb_write_only: assert property (@(posedge pcie_user_clk) disable iff (rst_i)
        !icap_rdwrb_i)
        else $error("icap_rdwrb_o went high");

    // A DUT drive against the testbench shows up as X on the pad
    dq_released: assert property (@(posedge pcie_user_clk) disable iff (rst_i)
        !dq_oe_i |-> !$isunknown(flash_dq_i))
        else $error("flash dq pad contended while enable is low");

endmodule

bind board_io_top board_io_properties u_props (
    .pcie_user_clk (pcie_user_clk),
    .rst_i         (rst_i),
    .icap_csib_i   (icap_csib_o),
    .icap_rdwrb_i  (icap_rdwrb_o),
    .dq_oe_i       (u_flash_pad_reg.drive_q.dq_oe),
    .flash_dq_i    (flash_dq_io)
);

`default_nettype wire

// File: tb/tb_board_io.sv
// Reads tb/board_io_golden.txt from the project root; sections must keep the order of that file
`timescale 1ns/100ps
`default_nettype none

module tb_board_io import board_io_pkg::*; ();

    logic                    pcie_user_clk;
    logic                    rst_i;
    logic                    fpga_boot;
    logic                    icap_avail;
    board_status_t           status_pins;
    i2c_drive_t              i2c_drive;
    flash_drive_t            flash_drive;
    board_status_t           status_o;
    logic [FLASH_DQ_W-1:0]   flash_dq_sync_o;
    logic [FLASH_ADDR_W-1:0] flash_addr_o;
    logic                    flash_ce_n_o;
    logic                    flash_oe_n_o;
    logic                    flash_we_n_o;
    logic                    flash_adv_n_o;
    logic                    icap_csib_o;
    logic                    icap_rdwrb_o;
    logic [ICAP_WORD_W-1:0]  icap_di_o;
    wire                     sfp_scl;
    wire                     sfp_1_sda;
    wire                     sfp_2_sda;
    wire                     eeprom_scl;
    wire                     eeprom_sda;
    wire  [FLASH_DQ_W-1:0]   flash_dq;
    wire                     flash_region;
    logic                    tb_dq_en;
    logic [FLASH_DQ_W-1:0]   tb_dq;
    int                      n_checks;
    int                      n_errors;
    int                      n_timeouts;

    board_io_top u_dut (
        .pcie_user_clk     (pcie_user_clk),
        .rst_i             (rst_i),
        .fpga_boot_i       (fpga_boot),
        .icap_avail_i      (icap_avail),
        .status_pins_i     (status_pins),
        .i2c_drive_i       (i2c_drive),
        .flash_drive_i     (flash_drive),
        .status_o          (status_o),
        .flash_dq_sync_o   (flash_dq_sync_o),
        .sfp_i2c_scl_io    (sfp_scl),
        .sfp_1_i2c_sda_io  (sfp_1_sda),
        .sfp_2_i2c_sda_io  (sfp_2_sda),
        .eeprom_i2c_scl_io (eeprom_scl),
        .eeprom_i2c_sda_io (eeprom_sda),
        .flash_dq_io       (flash_dq),
        .flash_region_io   (flash_region),
        .flash_addr_o      (flash_addr_o),
        .flash_ce_n_o      (flash_ce_n_o),
        .flash_oe_n_o      (flash_oe_n_o),
        .flash_we_n_o      (flash_we_n_o),
        .flash_adv_n_o     (flash_adv_n_o),
        .icap_csib_o       (icap_csib_o),
        .icap_rdwrb_o      (icap_rdwrb_o),
        .icap_di_o         (icap_di_o)
    );

    // Board pull-ups
    pullup (sfp_scl);
    pullup (sfp_1_sda);
    pullup (sfp_2_sda);
    pullup (eeprom_scl);
    pullup (eeprom_sda);
    pullup (flash_region);
    for (genvar i = 0; i < FLASH_DQ_W; i++) begin : g_dq_pull
        pullup (flash_dq[i]);
    end

    // Flash device drives the bus only while the DUT has released it
    assign flash_dq = (tb_dq_en && !u_dut.u_flash_pad_reg.drive_q.dq_oe) ? tb_dq : 'z;

    always #5 pcie_user_clk = ~pcie_user_clk;

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge pcie_user_clk);
        #1;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) next_cycle();
    endtask

    task automatic wait_csib_low(input int limit, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            next_cycle();
            ok = (icap_csib_o === 1'b0);
            n++;
        end
    endtask

    task automatic run_boot(input logic avail, input logic [5:0][31:0] words);
        bit ok;
        fpga_boot  = 1'b1;
        icap_avail = avail;
        if (!avail) begin
            for (int n = 0; n < 12; n++) begin
                next_cycle();
                check("icap_csib_o while port unavailable", icap_csib_o, 1'b1);
            end
            icap_avail = 1'b1;
        end
        wait_csib_low(20, ok);
        fpga_boot = 1'b0;
        if (!ok) begin
            n_timeouts++;
            $display("timeout: chip select never went low after the boot request");
        end else begin
            check("icap_di_o word 0", icap_di_o, words[5]);
            for (int n = 1; n < 6; n++) begin
                next_cycle();
                check("icap_csib_o in sequence", icap_csib_o, 1'b0);
                check("icap_di_o", icap_di_o, words[5-n]);
                check("icap_rdwrb_o", icap_rdwrb_o, 1'b0);
            end
            // Returns high and must not restart once the request is gone
            for (int n = 0; n < 5; n++) begin
                next_cycle();
                check("icap_csib_o after sequence", icap_csib_o, 1'b1);
                check("icap_di_o after sequence", icap_di_o, words[5]);
            end
        end
    endtask

    initial begin
        logic [8*128-1:0] line;
        logic [8*8-1:0]   tag;
        logic [31:0]      v [0:11];
        int               fd;
        int               cnt;
        bit               done;

        pcie_user_clk = 1'b0;
        rst_i         = 1'b1;
        fpga_boot     = 1'b0;
        icap_avail    = 1'b1;
        status_pins   = '0;
        i2c_drive     = I2C_DRIVE_IDLE;
        flash_drive   = FLASH_DRIVE_IDLE;
        tb_dq_en      = 1'b0;
        tb_dq         = '0;
        n_checks      = 0;
        n_errors      = 0;
        n_timeouts    = 0;
        done          = 1'b0;
        void'($urandom(75742));

        repeat (5) @(posedge pcie_user_clk);
        #1;
        rst_i = 1'b0;
        next_cycle();

        // Inactive outputs after reset
        check("icap_csib_o after reset", icap_csib_o, 1'b1);
        check("icap_rdwrb_o after reset", icap_rdwrb_o, 1'b0);
        check("icap_di_o after reset", icap_di_o, 32'hFFFF_FFFF);
        check("i2c pads after reset", {sfp_scl, sfp_1_sda, sfp_2_sda, eeprom_scl, eeprom_sda},
            5'h1F);
        check("flash dq after reset", flash_dq, 16'hFFFF);
        check("flash region after reset", flash_region, 1'b1);
        check("flash strobes after reset", {flash_ce_n_o, flash_oe_n_o, flash_we_n_o}, 3'b111);

        fd = $fopen("tb/board_io_golden.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("could not open the golden file tb/board_io_golden.txt");
            done = 1'b1;
        end
        while (!done) begin
            line = '0;
            tag  = '0;
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else if ($sscanf(line, "%s", tag) != 1 || tag == "#") begin
                // Blank or comment line
            end else if (tag == "I2C") begin
                cnt = $sscanf(line, "%s %h %h", tag, v[1], v[2]);
                check("fields in golden I2C line", cnt, 3);
                i2c_drive = v[1][9:0];
                next_cycle();
                check("i2c pads", {sfp_scl, sfp_1_sda, sfp_2_sda, eeprom_scl, eeprom_sda},
                    v[2][4:0]);
                idle_gap();
            end else if (tag == "FLASH") begin
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", tag, v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
                check("fields in golden FLASH line", cnt, 12);
                flash_drive = '{dq_o: v[1][15:0], dq_oe: v[2][0], addr: v[3][22:0],
                    region: v[4][0], region_oe: v[5][0], ce_n: v[6][0], oe_n: v[7][0],
                    we_n: v[8][0], adv_n: v[9][0]};
                next_cycle();
                check("flash_addr_o", flash_addr_o, v[3][22:0]);
                check("flash strobes", {flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o},
                    {v[6][0], v[7][0], v[8][0], v[9][0]});
                check("flash dq pad", flash_dq, v[10][15:0]);
                check("flash region pad", flash_region, v[11][0]);
                idle_gap();
            end else if (tag == "STATUS") begin
                cnt = $sscanf(line, "%s %h %h %h %h", tag, v[1], v[2], v[3], v[4]);
                check("fields in golden STATUS line", cnt, 5);
                // I2C sense fields driven to 0 as the top must ignore them
                status_pins = {v[1][3:0], 5'b00000};
                tb_dq       = v[2][15:0];
                tb_dq_en    = 1'b1;
                next_cycle();
                next_cycle();
                check("status_o", status_o, v[3][8:0]);
                check("flash_dq_sync_o", flash_dq_sync_o, v[4][15:0]);
                idle_gap();
            end else if (tag == "BOOT") begin
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h", tag, v[1], v[2], v[3], v[4],
                    v[5], v[6], v[7]);
                check("fields in golden BOOT line", cnt, 8);
                run_boot(v[1][0], {v[2], v[3], v[4], v[5], v[6], v[7]});
                idle_gap();
            end else begin
                n_errors++;
                $display("unknown line in the golden file: %0s", tag);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("checks %0d, value errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/board_io_golden.txt
# I2C    drive(10b hex)  expected pads {sfp_scl,sfp_1_sda,sfp_2_sda,eeprom_scl,eeprom_sda}
# FLASH  dq_o dq_oe addr region region_oe ce_n oe_n we_n adv_n  exp_dq exp_region
# STATUS pins{npres1,npres2,los1,los2} dq  exp_status(9b) exp_dq_sync
# BOOT   avail  six reversed words on consecutive low chip select cycles
I2C 3FF 1F
I2C 000 00
I2C 2AA 1F
I2C 155 1F
I2C 200 10
I2C 0C3 09
I2C 028 06
I2C 3FF 1F
# Released pads and disabled dq/region read the pull-up value
FLASH 1234 1 000001 1 1 0 1 1 0 1234 1
FLASH ABCD 0 7FFFFF 0 1 0 0 1 1 FFFF 0
FLASH 0000 1 2AAAAA 0 0 1 0 0 0 0000 1
FLASH 5A5A 1 155555 1 0 0 1 0 1 5A5A 1
FLASH FFFF 0 000000 0 1 1 1 1 1 FFFF 0
FLASH 0F0F 0 400000 1 0 1 1 1 1 FFFF 1
# All I2C lines are released here, so the five sense bits read 1
STATUS 0 0000 01F 0000
STATUS F FFFF 1FF FFFF
STATUS A 1234 15F 1234
STATUS 5 C3C3 0BF C3C3
STATUS 9 8001 13F 8001
STATUS 6 7FFE 0DF 7FFE
STATUS 3 A5A5 07F A5A5
# Dummy, sync, no-op, write command, reprogram, no-op
BOOT 1 FFFFFFFF 5599AA66 04000000 0C000180 000000F0 04000000
BOOT 0 FFFFFFFF 5599AA66 04000000 0C000180 000000F0 04000000
BOOT 1 FFFFFFFF 5599AA66 04000000 0C000180 000000F0 04000000

// File: src.f
source/board_io_pkg.sv
source/signal_sync.sv
source/i2c_pad_reg.sv
source/flash_pad_reg.sv
source/icap_reboot_seq.sv
source/board_io_top.sv
tb/board_io_properties.sv
tb/tb_board_io.sv

// File: Bender.yml
package:
  name: board_io

sources:
  # Design
  - source/board_io_pkg.sv
  - source/signal_sync.sv
  - source/i2c_pad_reg.sv
  - source/flash_pad_reg.sv
  - source/icap_reboot_seq.sv
  - source/board_io_top.sv

  # Verification
  - target: simulation
    files:
      - tb/board_io_properties.sv
      - tb/tb_board_io.sv
